// File: common/residue_pkg.sv
/*
 * Modulo-3 residue type and the constant functions that size the
 * residue generator tree and fold a carry or borrow into a residue
 */

package residue_pkg;

  // Two-bit residue modulo 3, where the pattern 3 is read as 0
  typedef logic [1:0] residue_t;

  // Ceiling base-2 logarithm, so res_logb2(4) is 2 and res_logb2(5) is 3
  function automatic int res_logb2(input int value);
    int result;
    result = 0;
    while ((1 << result) < value) begin
      result = result + 1;
    end
    return result;
  endfunction

  // Residue of two to the power of width
  // Powers of four are 1 mod 3, so only the parity of the width matters
  function automatic residue_t res_pow2(input int width);
    residue_t result;
    if ((width % 2) == 0) begin
      result = 2'd1;
    end else begin
      result = 2'd2;
    end
    return result;
  endfunction

endpackage : residue_pkg

// File: common/acc_pkg.sv
/*
 * Accumulator opcodes and the default datapath width
 */

package acc_pkg;

  // -------------------------------------------------------------------
  // Datapath width
  // -------------------------------------------------------------------

  // The top level hands this down to every block as WIDTH
  localparam int ACC_WIDTH = 16;

  // -------------------------------------------------------------------
  // Opcodes
  // -------------------------------------------------------------------

  // One operation is taken per op_valid strobe
  // op_clear also drops both sticky error flags
  typedef enum logic [1:0] {
    op_load  = 2'd0,
    op_add   = 2'd1,
    op_sub   = 2'd2,
    op_clear = 2'd3
  } acc_op_e;

endpackage : acc_pkg

// File: residue/residue_add.sv
/*
 * Modulo-3 adder for two 2-bit residues
 */

module residue_add
  import residue_pkg::*;
(
  input  residue_t a
, input  residue_t b
, output residue_t r
);

  residue_t a_norm;
  residue_t b_norm;
  logic [2:0] sum;

  // A pattern of 3 is congruent to 0, so fold it away before adding
  assign a_norm = (a == 2'd3) ? 2'd0 : a;
  assign b_norm = (b == 2'd3) ? 2'd0 : b;

  // Both operands are now 0..2, so the raw sum is at most 4
  assign sum = {1'b0, a_norm} + {1'b0, b_norm};

  // One conditional subtract of 3 brings the sum back into 0..2
  assign r = (sum >= 3'd3) ? residue_t'(sum - 3'd3) : residue_t'(sum);

  // The output must always be a legal residue whatever the inputs carry
  // Unknown inputs at start-up are not a design error
  always_comb begin
    r_legal_a: assert final ($isunknown({a, b}) || (r != 2'd3))
      else $error("residue_add produced the illegal residue 3");
  end

endmodule : residue_add

// File: residue/residue_gen.sv
/*
 * Residue generator that reduces a WIDTH-bit word to its modulo-3
 * residue through a balanced tree of residue adders
 */

module residue_gen
  import residue_pkg::*;
#(
  parameter int WIDTH = 4
) (
  input  logic [WIDTH-1:0] a
, output residue_t         r
);

  // -------------------------------------------------------------------
  // Tree sizing
  // -------------------------------------------------------------------

  // The tree wants at least two pairs and a power-of-two width
  localparam int WIDTH_ADJ = (WIDTH < 4) ? 4 : WIDTH;
  localparam int WIDTH_PAD = 1 << res_logb2(WIDTH_ADJ);

  // Number of 2-bit leaves, which is also the widest level of the tree
  localparam int PAIRS = WIDTH_PAD / 2;

  // Level DEPTH holds the leaves and level 0 the final residue
  localparam int DEPTH = res_logb2(PAIRS);

  logic [WIDTH_PAD-1:0] a_pad;

  // One residue per slot per level
  // Level n only has 2**n live slots, the rest are tied to zero
  residue_t lvl_res [DEPTH:0][PAIRS-1:0];

  // Zero padding does not change the residue of the word
  always_comb begin
    a_pad            = '0;
    a_pad[WIDTH-1:0] = a;
  end

  // -------------------------------------------------------------------
  // Reduction tree
  // -------------------------------------------------------------------

  // Every 2-bit pair has weight 4**i, which is 1 mod 3, so the leaf
  // residues can simply be summed modulo 3
  for (genvar lev = 0; lev <= DEPTH; lev++) begin : g_lev
    for (genvar ix = 0; ix < PAIRS; ix++) begin : g_ix
      if (ix >= (1 << lev)) begin : g_tie
        // Slot is above the live width of this level
        assign lvl_res[lev][ix] = 2'd0;
      end else if (lev == DEPTH) begin : g_leaf
        // A pair of value 3 is already 0 mod 3
        assign lvl_res[lev][ix] = (a_pad[2*ix +: 2] == 2'd3) ? 2'd0 : a_pad[2*ix +: 2];
      end else begin : g_node
        // Combine two neighbours from the level below
        residue_add res_add (
          .a ( lvl_res[lev+1][2*ix]   )
        , .b ( lvl_res[lev+1][2*ix+1] )
        , .r ( lvl_res[lev][ix]       )
        );
      end
    end
  end

  assign r = lvl_res[0][0];

endmodule : residue_gen

// File: source/residue_acc_alu.sv
/*
 * Accumulator ALU with the next value and a residue predicted from
 * the operand residues and the carry or borrow of the data path
 */

module residue_acc_alu
  import acc_pkg::*;
  import residue_pkg::*;
#(
  parameter int WIDTH = ACC_WIDTH
) (
  input  acc_op_e          op
, input  logic [WIDTH-1:0] acc
, input  residue_t         acc_res
, input  logic [WIDTH-1:0] operand
, input  residue_t         operand_res
, output logic [WIDTH-1:0] next_acc
, output residue_t         next_res
);

  // Residue of the 2**WIDTH that a carry drops or a borrow adds
  localparam residue_t POW2_RES = res_pow2(WIDTH);

  // Same quantity negated mod 3, used to take a carry back out
  localparam residue_t POW2_NEG = (POW2_RES == 2'd1) ? 2'd2 : 2'd1;

  // -------------------------------------------------------------------
  // Data path
  // -------------------------------------------------------------------

  logic [WIDTH:0] sum_ext;
  logic [WIDTH:0] diff_ext;
  logic           carry;
  logic           borrow;

  // One extra bit catches the carry out and the borrow
  assign sum_ext  = {1'b0, acc} + {1'b0, operand};
  assign diff_ext = {1'b0, acc} - {1'b0, operand};
  assign carry    = sum_ext[WIDTH];
  assign borrow   = diff_ext[WIDTH];

  // -------------------------------------------------------------------
  // Residue path
  // -------------------------------------------------------------------

  // The residue is only ever built from the stored and supplied residues,
  // never from the result bits, so an error in the adder shows up later
  // in the storage check
  residue_t opnd_res_adj;
  residue_t base_res;
  residue_t fix_res;
  residue_t arith_res;
  residue_t load_res;

  // Subtraction adds the negated operand residue, negation swaps 1 and 2
  always_comb begin
    opnd_res_adj = operand_res;
    if (op == op_sub) begin
      case (operand_res)
        2'd1:    opnd_res_adj = 2'd2;
        2'd2:    opnd_res_adj = 2'd1;
        default: opnd_res_adj = 2'd0;
      endcase
    end
  end

  // Wrap correction. A carry out removes 2**WIDTH from the true sum
  // and a borrow adds 2**WIDTH to the true difference
  always_comb begin
    fix_res = 2'd0;
    if ((op == op_add) && carry) begin
      fix_res = POW2_NEG;
    end else if ((op == op_sub) && borrow) begin
      fix_res = POW2_RES;
    end
  end

  residue_add res_sum (
    .a ( acc_res      )
  , .b ( opnd_res_adj )
  , .r ( base_res     )
  );

  residue_add res_fix (
    .a ( base_res  )
  , .b ( fix_res   )
  , .r ( arith_res )
  );

  // Keep a supplied pattern of 3 out of the stored residue
  assign load_res = (operand_res == 2'd3) ? 2'd0 : operand_res;

  // -------------------------------------------------------------------
  // Result select
  // -------------------------------------------------------------------

  always_comb begin
    next_acc = '0;
    next_res = 2'd0;
    case (op)
      op_load: begin
        next_acc = operand;
        next_res = load_res;
      end
      op_add: begin
        next_acc = sum_ext[WIDTH-1:0];
        next_res = arith_res;
      end
      op_sub: begin
        next_acc = diff_ext[WIDTH-1:0];
        next_res = arith_res;
      end
      default: begin
        // Clear leaves both at zero
        next_acc = '0;
        next_res = 2'd0;
      end
    endcase
  end

endmodule : residue_acc_alu

// File: source/residue_acc.sv
/*
 * Residue-protected accumulator with its state registers, the input and
 * storage residue checkers, fault injection and sticky error flags
 */

module residue_acc
  import acc_pkg::*;
  import residue_pkg::*;
#(
  parameter int WIDTH = ACC_WIDTH
) (
  input  logic             clk
, input  logic             rst_n
, input  logic             op_valid
, input  acc_op_e          op
, input  logic [WIDTH-1:0] operand
, input  residue_t         operand_res
, input  logic             inj_flip
, output logic [WIDTH-1:0] acc
, output residue_t         acc_res
, output logic             err_in
, output logic             err_acc
);

  logic [WIDTH-1:0] next_acc;
  residue_t         next_res;
  logic [WIDTH-1:0] wr_acc;
  residue_t         wr_res;
  logic [WIDTH-1:0] flip_mask;
  residue_t         in_gen_res;
  residue_t         store_gen_res;
  residue_t         operand_res_norm;
  logic             clear_op;
  logic             in_mismatch;
  logic             acc_mismatch;

  // -------------------------------------------------------------------
  // Next state and storage
  // -------------------------------------------------------------------

  residue_acc_alu #(
    .WIDTH ( WIDTH )
  ) acc_alu (
    .op          ( op          )
  , .acc         ( acc         )
  , .acc_res     ( acc_res     )
  , .operand     ( operand     )
  , .operand_res ( operand_res )
  , .next_acc    ( next_acc    )
  , .next_res    ( next_res    )
  );

  // Without a strobe the register simply holds its value
  assign wr_acc = op_valid ? next_acc : acc;
  assign wr_res = op_valid ? next_res : acc_res;

  // Injection only touches bit 0 of the data, the residue goes in as is
  always_comb begin
    flip_mask    = '0;
    flip_mask[0] = inj_flip;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc     <= '0;
      acc_res <= 2'd0;
    end else begin
      acc     <= wr_acc ^ flip_mask;
      acc_res <= wr_res;
    end
  end

  // -------------------------------------------------------------------
  // Residue checkers
  // -------------------------------------------------------------------

  // Input check, compares the operand with the residue it came with
  residue_gen #(
    .WIDTH ( WIDTH )
  ) input_gen (
    .a ( operand    )
  , .r ( in_gen_res )
  );

  // Storage check, runs on the held value every cycle
  residue_gen #(
    .WIDTH ( WIDTH )
  ) store_gen (
    .a ( acc           )
  , .r ( store_gen_res )
  );

  assign clear_op         = op_valid && (op == op_clear);
  assign operand_res_norm = (operand_res == 2'd3) ? 2'd0 : operand_res;

  // A clear does not use the operand, so its residue is not checked
  assign in_mismatch  = op_valid && (op != op_clear) && (in_gen_res != operand_res_norm);
  assign acc_mismatch = (store_gen_res != acc_res);

  // Sticky flags, and a clear beats a mismatch seen at the same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_in  <= 1'b0;
      err_acc <= 1'b0;
    end else if (clear_op) begin
      err_in  <= 1'b0;
      err_acc <= 1'b0;
    end else begin
      if (in_mismatch) begin
        err_in <= 1'b1;
      end
      if (acc_mismatch) begin
        err_acc <= 1'b1;
      end
    end
  end

  // -------------------------------------------------------------------
  // Assertions
  // -------------------------------------------------------------------

  // The stored residue is always one of the legal values 0, 1 or 2
  acc_res_legal_a: assert property (
    @(posedge clk) disable iff (!rst_n) acc_res != 2'd3
  ) else $error("Stored residue holds the illegal pattern 3");

  // A clear strobe leaves both flags low at the following cycle
  clear_drops_err_a: assert property (
    @(posedge clk) disable iff (!rst_n) clear_op |=> (!err_in && !err_acc)
  ) else $error("Error flags still set after op_clear");

  // A consistent pair stays consistent through any operation, as long as
  // nothing is injected and the operand residue is correct.
  // This ties the ALU residue prediction to the generator tree
  store_consistent_a: assert property (
    @(posedge clk) disable iff (!rst_n)
      (!inj_flip && !in_mismatch && !acc_mismatch) |=> !acc_mismatch
  ) else $error("Predicted residue disagrees with the stored value");

endmodule : residue_acc

// File: verif/residue_acc_tb.sv
/*
 * Testbench for the residue-protected accumulator with clock, reset,
 * random stimulus, a reference model and concurrent assertions
 */

module residue_acc_tb
  import acc_pkg::*;
  import residue_pkg::*;
();

  logic                 clk;
  logic                 rst_n;
  logic                 op_valid;
  acc_op_e              op;
  logic [ACC_WIDTH-1:0] operand;
  residue_t             operand_res;
  logic                 inj_flip;
  logic [ACC_WIDTH-1:0] acc;
  residue_t             acc_res;
  logic                 err_in;
  logic                 err_acc;

  integer seed;
  int     err_count;
  int     tests_run;
  int     tests_failed;

  residue_acc #(
    .WIDTH ( ACC_WIDTH )
  ) residue_acc_i (
    .clk         ( clk         )
  , .rst_n       ( rst_n       )
  , .op_valid    ( op_valid    )
  , .op          ( op          )
  , .operand     ( operand     )
  , .operand_res ( operand_res )
  , .inj_flip    ( inj_flip    )
  , .acc         ( acc         )
  , .acc_res     ( acc_res     )
  , .err_in      ( err_in      )
  , .err_acc     ( err_acc     )
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // -------------------------------------------------------------------
  // Reference model
  // -------------------------------------------------------------------

  logic [ACC_WIDTH-1:0] exp_acc;
  residue_t             exp_res;
  logic                 exp_err_in;
  logic                 exp_err_acc;
  logic [ACC_WIDTH-1:0] m_val;
  int                   m_res;
  int                   opres_val;
  int                   store_off;
  int                   opnd_off;

  // The expected residue is the model value mod 3, shifted by how far the
  // stored and the supplied residues are off from their data
  // A corrupted operand residue therefore leaves a mismatched pair in storage
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_acc     <= '0;
      exp_res     <= 2'd0;
      exp_err_in  <= 1'b0;
      exp_err_acc <= 1'b0;
    end else begin
      m_val     = exp_acc;
      m_res     = exp_res;
      opres_val = (operand_res == 2'd3) ? 0 : operand_res;
      store_off = (exp_res + 3 - (exp_acc % 3)) % 3;
      opnd_off  = (opres_val + 3 - (operand % 3)) % 3;
      if (op_valid) begin
        // Sums and differences wrap around in the datapath width
        case (op)
          op_load: begin
            m_val = operand;
            m_res = ((m_val % 3) + opnd_off) % 3;
          end
          op_add: begin
            m_val = exp_acc + operand;
            m_res = ((m_val % 3) + store_off + opnd_off) % 3;
          end
          op_sub: begin
            m_val = exp_acc - operand;
            m_res = ((m_val % 3) + store_off + 3 - opnd_off) % 3;
          end
          default: begin
            m_val = '0;
            m_res = 0;
          end
        endcase
      end
      // Injection flips bit 0 of whatever is written and leaves the residue alone
      if (inj_flip) begin
        m_val[0] = ~m_val[0];
      end
      exp_acc <= m_val;
      exp_res <= residue_t'(m_res);
      if (op_valid && (op == op_clear)) begin
        exp_err_in  <= 1'b0;
        exp_err_acc <= 1'b0;
      end else begin
        if (op_valid && (opnd_off != 0)) begin
          exp_err_in <= 1'b1;
        end
        if (store_off != 0) begin
          exp_err_acc <= 1'b1;
        end
      end
    end
  end

  // -------------------------------------------------------------------
  // Assertions
  // -------------------------------------------------------------------

  acc_value_a: assert property (@(posedge clk) disable iff (!rst_n) acc == exp_acc)
    else begin
      err_count = err_count + 1;
      $display("Fail at %0t: acc is %h, expected %h", $time, $sampled(acc), $sampled(exp_acc));
    end

  acc_res_a: assert property (@(posedge clk) disable iff (!rst_n) acc_res == exp_res)
    else begin
      err_count = err_count + 1;
      $display("Fail at %0t: acc_res is %0d, expected %0d",
               $time, $sampled(acc_res), $sampled(exp_res));
    end

  err_in_a: assert property (@(posedge clk) disable iff (!rst_n) err_in == exp_err_in)
    else begin
      err_count = err_count + 1;
      $display("Fail at %0t: err_in is %b, expected %b",
               $time, $sampled(err_in), $sampled(exp_err_in));
    end

  err_acc_a: assert property (@(posedge clk) disable iff (!rst_n) err_acc == exp_err_acc)
    else begin
      err_count = err_count + 1;
      $display("Fail at %0t: err_acc is %b, expected %b",
               $time, $sampled(err_acc), $sampled(exp_err_acc));
    end

  // A clear zeroes the pair and both flags one cycle after the strobe
  clear_result_a: assert property (@(posedge clk) disable iff (!rst_n)
    (op_valid && (op == op_clear)) |=> (acc == '0) && (acc_res == 2'd0) && !err_in && !err_acc)
    else begin
      err_count = err_count + 1;
      $display("Fail at %0t: state not cleared after op_clear", $time);
    end

  // A lone injection flips bit 0 and keeps the stored residue
  flip_effect_a: assert property (@(posedge clk) disable iff (!rst_n)
    (inj_flip && !op_valid) |=> (acc[0] != $past(acc[0])) && (acc_res == $past(acc_res)))
    else begin
      err_count = err_count + 1;
      $display("Fail at %0t: inj_flip did not flip only bit 0 of acc", $time);
    end

  // -------------------------------------------------------------------
  // Stimulus tasks
  // -------------------------------------------------------------------

  // Drives one strobed operation
  // A corrupted residue is off by one mod 3
  task automatic issue_op(input acc_op_e o, input logic [ACC_WIDTH-1:0] v, input bit corrupt);
    residue_t good_res;
    good_res = residue_t'(v % 3);
    @(posedge clk);
    #2;
    op_valid    = 1'b1;
    op          = o;
    operand     = v;
    operand_res = corrupt ? residue_t'((good_res + 1) % 3) : good_res;
    @(posedge clk);
    #2;
    op_valid = 1'b0;
  endtask

  task automatic pulse_flip();
    @(posedge clk);
    #2;
    inj_flip = 1'b1;
    @(posedge clk);
    #2;
    inj_flip = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
    end
  endtask

  // Polls one flag after each edge and gives up after max_cycles
  task automatic wait_for_flag(input bit on_acc, input int max_cycles);
    int n;
    n = 0;
    while (!(on_acc ? err_acc : err_in) && (n < max_cycles)) begin
      @(posedge clk);
      #2;
      n = n + 1;
    end
    if (!(on_acc ? err_acc : err_in)) begin
      err_count = err_count + 1;
      $display("Timeout at %0t: %s did not rise within %0d cycles",
               $time, on_acc ? "err_acc" : "err_in", max_cycles);
    end
  endtask

  // Lets late assertions settle and then reports the test
  task automatic finish_test(input string name, input int start_errs);
    int n;
    idle_cycles(2);
    n = err_count - start_errs;
    tests_run = tests_run + 1;
    if (n != 0) begin
      tests_failed = tests_failed + 1;
    end
    $display("Test %s finished with %0d errors", name, n);
  endtask

  task automatic run_clear_test(input string name);
    int start;
    start = err_count;
    // The corrupted operand residue must not raise err_in on a clear
    issue_op(op_clear, 16'($random(seed)), 1'b1);
    finish_test(name, start);
  endtask

  // -------------------------------------------------------------------
  // Test sequence
  // -------------------------------------------------------------------

  initial begin
    int start;
    int sel;
    seed         = 32'h8749_9a66;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst_n        = 1'b0;
    op_valid     = 1'b0;
    op           = op_load;
    operand      = '0;
    operand_res  = 2'd0;
    inj_flip     = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;

    start = err_count;
    idle_cycles(3);
    finish_test("reset", start);

    // A forced carry and borrow come first and a random mix follows
    start = err_count;
    issue_op(op_load, 16'hfff0, 1'b0);
    issue_op(op_add, 16'h0020, 1'b0);
    issue_op(op_sub, 16'h8000, 1'b0);
    for (int i = 0; i < 40; i++) begin
      sel = $random(seed) & 3;
      case (sel)
        0:       issue_op(op_load, 16'($random(seed)), 1'b0);
        2:       issue_op(op_sub, 16'($random(seed)), 1'b0);
        default: issue_op(op_add, 16'($random(seed)), 1'b0);
      endcase
    end
    finish_test("arith", start);

    start = err_count;
    issue_op(op_load, 16'($random(seed)), 1'b1);
    wait_for_flag(1'b0, 3);
    issue_op(op_add, 16'($random(seed)), 1'b0);
    issue_op(op_add, 16'($random(seed)), 1'b1);
    issue_op(op_sub, 16'($random(seed)), 1'b0);
    finish_test("input_check", start);

    run_clear_test("clear");

    start = err_count;
    issue_op(op_load, 16'($random(seed)), 1'b0);
    pulse_flip();
    wait_for_flag(1'b1, 4);
    finish_test("fault", start);

    run_clear_test("clear_after_fault");

    $display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, err_count);
    if (err_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule : residue_acc_tb

// File: vlog.f
common/residue_pkg.sv
common/acc_pkg.sv
residue/residue_add.sv
residue/residue_gen.sv
source/residue_acc_alu.sv
source/residue_acc.sv
verif/residue_acc_tb.sv
